/* hw/debug_regs.sv */
`default_nettype none

module debug_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stb,
	input  logic              we,
	input  logic [1:0]        adr,
	input  ledspi_pkg::data_t dat_w,
	output ledspi_pkg::data_t dat_r,
	output logic              ack,
	output ledspi_pkg::data_t debug
);
	import ledspi_pkg::*;

	// 0 drives the pins, 1..3 scratch for host read-back
	data_t regs [4];

	// registered ack, one cycle after stb
	always_ff @(posedge clk) begin
		if (!rst_n)
			ack <= 1'b0;
		else
			ack <= stb & ~ack;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else if (stb && !ack && we) begin
			regs[adr] <= dat_w;
		end
	end

	// read data only sampled while ack is high
	assign dat_r = regs[adr];

	// pins follow register 0 directly
	assign debug = regs[0];

endmodule

`default_nettype wire

/* hw/ledspi_pkg.sv */
`default_nettype none

package ledspi_pkg;

	// one byte on the internal bus
	typedef logic [7:0] data_t;

	// bus address, matches the default addr_len of the top level
	typedef logic [3:0] addr_t;

	// pwm duty and free running counter
	typedef logic [7:0] duty_t;

	// bridge sequencer
	//   st_idle  waiting for csn to fall
	//   st_cmd   shifting in the command byte
	//   st_bus   bus cycle outstanding, waiting for ack
	//   st_data  second byte, shifted in for writes or out for reads
	typedef enum logic [1:0] {
		st_idle,
		st_cmd,
		st_bus,
		st_data
	} bridge_state_t;

	// address map, each peripheral spans four bytes
	// rgb: 0 red, 1 green, 2 blue, 3 reads 0
	localparam addr_t RGB_BASE = 4'h0;

	// debug: 4 drives the pins, 5..7 scratch
	localparam addr_t DBG_BASE = 4'h4;

endpackage

`default_nettype wire

/* hw/ledspi_top.sv */
`default_nettype none

module ledspi_top #(
	parameter int addr_len = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              spi_sck,
	input  logic              spi_csn,
	input  logic              spi_sdi,
	output logic              spi_sdo,
	output logic [2:0]        rgb,
	output ledspi_pkg::data_t debug
);
	import ledspi_pkg::*;

	// bridge side of the bus
	addr_t bus_adr;
	data_t bus_dat_w;
	data_t bus_dat_r;
	logic bus_we;
	logic bus_stb;
	logic bus_ack;

	// per peripheral strobe and return path
	logic rgb_stb;
	logic dbg_stb;
	data_t rgb_dat_r;
	data_t dbg_dat_r;
	logic rgb_ack;
	logic dbg_ack;

	// spi frame to one bus cycle
	spi_wb_ctrl #(
		.addr_len(addr_len)
	) u_bridge (
		.clk     (clk),
		.rst_n   (rst_n),
		.spi_sck (spi_sck),
		.spi_csn (spi_csn),
		.spi_sdi (spi_sdi),
		.spi_sdo (spi_sdo),
		.adr     (bus_adr),
		.dat_w   (bus_dat_w),
		.we      (bus_we),
		.stb     (bus_stb),
		.dat_r   (bus_dat_r),
		.ack     (bus_ack)
	);

	wb_periph_decode #(
		.addr_len(addr_len)
	) u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.adr       (bus_adr),
		.stb       (bus_stb),
		.dat_r     (bus_dat_r),
		.ack       (bus_ack),
		.rgb_stb   (rgb_stb),
		.dbg_stb   (dbg_stb),
		.rgb_dat_r (rgb_dat_r),
		.dbg_dat_r (dbg_dat_r),
		.rgb_ack   (rgb_ack),
		.dbg_ack   (dbg_ack)
	);

	// peripherals only see the register index
	rgb_pwm u_rgb (
		.clk   (clk),
		.rst_n (rst_n),
		.stb   (rgb_stb),
		.we    (bus_we),
		.adr   (bus_adr[1:0]),
		.dat_w (bus_dat_w),
		.dat_r (rgb_dat_r),
		.ack   (rgb_ack),
		.rgb   (rgb)
	);

	debug_regs u_dbg (
		.clk   (clk),
		.rst_n (rst_n),
		.stb   (dbg_stb),
		.we    (bus_we),
		.adr   (bus_adr[1:0]),
		.dat_w (bus_dat_w),
		.dat_r (dbg_dat_r),
		.ack   (dbg_ack),
		.debug (debug)
	);

endmodule

`default_nettype wire

/* hw/rgb_pwm.sv */
`default_nettype none

module rgb_pwm (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stb,
	input  logic              we,
	input  logic [1:0]        adr,
	input  ledspi_pkg::data_t dat_w,
	output ledspi_pkg::data_t dat_r,
	output logic              ack,
	output logic [2:0]        rgb
);
	import ledspi_pkg::*;

	// index 0 red, 1 green, 2 blue
	duty_t duty [3];
	duty_t cnt;
	logic wr;

	// write lands in the same cycle ack rises
	assign wr = stb & ~ack & we;

	// registered ack, one cycle after stb, never two in a row
	always_ff @(posedge clk) begin
		if (!rst_n)
			ack <= 1'b0;
		else
			ack <= stb & ~ack;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 3; i++)
				duty[i] <= '0;
		end else begin
			// index 3 has no register behind it
			for (int i = 0; i < 3; i++) begin
				if (wr && (adr == 2'(i)))
					duty[i] <= dat_w;
			end
		end
	end

	always_comb begin
		case (adr)
		2'd0: dat_r = duty[0];
		2'd1: dat_r = duty[1];
		2'd2: dat_r = duty[2];
		default: dat_r = '0;
		endcase
	end

	// free running, wraps every 256 clk
	always_ff @(posedge clk) begin
		if (!rst_n)
			cnt <= '0;
		else
			cnt <= cnt + 8'd1;
	end

	// output high while counter below duty
	// registered so the pins never glitch
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rgb <= 3'b000;
		end else begin
			for (int i = 0; i < 3; i++)
				rgb[i] <= (cnt < duty[i]);
		end
	end

endmodule

`default_nettype wire

/* hw/spi_wb_ctrl.sv */
`default_nettype none

module spi_wb_ctrl #(
	parameter int addr_len = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              spi_sck,
	input  logic              spi_csn,
	input  logic              spi_sdi,
	output logic              spi_sdo,
	output ledspi_pkg::addr_t adr,
	output ledspi_pkg::data_t dat_w,
	output logic              we,
	output logic              stb,
	input  ledspi_pkg::data_t dat_r,
	input  logic              ack
);
	import ledspi_pkg::*;

	// two flop synchronizers plus one more stage for edge detection
	logic [1:0] sck_sync;
	logic [1:0] csn_sync;
	logic [1:0] sdi_sync;
	logic sck_d;
	logic csn_d;

	logic sck_rise;
	logic sck_fall;
	logic csn_fall;
	logic csn_high;

	data_t sh_in;
	data_t sh_next;
	data_t sh_out;
	logic [3:0] bit_cnt;
	logic cmd_done;
	logic data_done;
	bridge_state_t state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sck_sync <= 2'b00;
			csn_sync <= 2'b11;
			sdi_sync <= 2'b00;
			sck_d    <= 1'b0;
			csn_d    <= 1'b1;
		end else begin
			sck_sync <= {sck_sync[0], spi_sck};
			csn_sync <= {csn_sync[0], spi_csn};
			sdi_sync <= {sdi_sync[0], spi_sdi};
			sck_d    <= sck_sync[1];
			csn_d    <= csn_sync[1];
		end
	end

	// mode 0: host samples on rising sck, we change sdo on falling
	assign sck_rise = sck_sync[1] & ~sck_d;
	assign sck_fall = ~sck_sync[1] & sck_d;
	assign csn_fall = ~csn_sync[1] & csn_d;
	assign csn_high = csn_sync[1];

	// msb first, so new bits enter at the bottom
	assign sh_next = {sh_in[6:0], sdi_sync[1]};

	// eighth bit closes the command byte, sixteenth the data byte
	assign cmd_done  = (state == st_cmd) && !csn_high && sck_rise && (bit_cnt == 4'd7);
	assign data_done = (state == st_data) && !csn_high && sck_rise && we &&
		(bit_cnt == 4'd15);

	always_ff @(posedge clk) begin
		if (sck_rise)
			sh_in <= sh_next;
		if (cmd_done)
			adr <= addr_t'(sh_next[addr_len-1:0]);
		if (data_done)
			dat_w <= sh_next;
	end

	assign spi_sdo = sh_out[7];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= st_idle;
			stb     <= 1'b0;
			we      <= 1'b0;
			bit_cnt <= 4'd0;
			sh_out  <= '0;
		end else begin
			case (state)
			st_idle: begin
				// frame starts on the falling csn edge only
				if (csn_fall) begin
					state   <= st_cmd;
					bit_cnt <= 4'd0;
				end
			end
			st_cmd: begin
				if (csn_high) begin
					state <= st_idle;
				end else if (sck_rise) begin
					bit_cnt <= bit_cnt + 4'd1;
					if (cmd_done) begin
						we <= sh_next[7];
						// a read goes out right away, a write waits for its data
						if (sh_next[7]) begin
							state <= st_data;
						end else begin
							state <= st_bus;
							stb   <= 1'b1;
						end
					end
				end
			end
			st_bus: begin
				// csn ignored here, the cycle in flight completes
				if (ack) begin
					stb <= 1'b0;
					if (we) begin
						state <= st_idle;
					end else begin
						sh_out <= dat_r;
						state  <= st_data;
					end
				end
			end
			st_data: begin
				if (csn_high) begin
					// aborted write never reaches the bus
					state  <= st_idle;
					sh_out <= '0;
				end else begin
					if (sck_rise)
						bit_cnt <= bit_cnt + 4'd1;
					if (data_done) begin
						state <= st_bus;
						stb   <= 1'b1;
					end
					// falling edge right after the command byte keeps the msb
					if (sck_fall && !we && (bit_cnt != 4'd8))
						sh_out <= {sh_out[6:0], 1'b0};
				end
			end
			default: begin
				state <= st_idle;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/wb_periph_decode.sv */
`default_nettype none

module wb_periph_decode #(
	parameter int addr_len = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  ledspi_pkg::addr_t adr,
	input  logic              stb,
	output ledspi_pkg::data_t dat_r,
	output logic              ack,
	output logic              rgb_stb,
	output logic              dbg_stb,
	input  ledspi_pkg::data_t rgb_dat_r,
	input  ledspi_pkg::data_t dbg_dat_r,
	input  logic              rgb_ack,
	input  logic              dbg_ack
);
	import ledspi_pkg::*;

	// map constants widened to the full address
	localparam logic [addr_len-1:0] rgb_base_full = addr_len'(RGB_BASE);
	localparam logic [addr_len-1:0] dbg_base_full = addr_len'(DBG_BASE);

	logic [addr_len-1:0] adr_full;
	logic sel_rgb;
	logic sel_dbg;
	logic miss_ack;

	assign adr_full = addr_len'(adr);

	// low two bits pick the register inside a peripheral
	assign sel_rgb = (adr_full[addr_len-1:2] == rgb_base_full[addr_len-1:2]);
	assign sel_dbg = (adr_full[addr_len-1:2] == dbg_base_full[addr_len-1:2]);

	assign rgb_stb = stb & sel_rgb;
	assign dbg_stb = stb & sel_dbg;

	// unmapped: answer ourselves so the bridge never hangs
	always_ff @(posedge clk) begin
		if (!rst_n)
			miss_ack <= 1'b0;
		else
			miss_ack <= stb & ~sel_rgb & ~sel_dbg & ~miss_ack;
	end

	always_comb begin
		if (sel_rgb) begin
			dat_r = rgb_dat_r;
			ack   = rgb_ack;
		end else if (sel_dbg) begin
			dat_r = dbg_dat_r;
			ack   = dbg_ack;
		end else begin
			dat_r = '0;
			ack   = miss_ack;
		end
	end

endmodule

`default_nettype wire

/* ledspi.f */
hw/ledspi_pkg.sv
hw/spi_wb_ctrl.sv
hw/wb_periph_decode.sv
hw/rgb_pwm.sv
hw/debug_regs.sv
hw/ledspi_top.sv
verif/tb_clkgen.sv
verif/ledspi_properties.sv
verif/ledspi_tb.sv

/* verif/ledspi_patterns.hex */
// kind adr data expect, one spi frame per line
// kind: high nibble test number, low nibble 0 write, 1 read, 2 write aborted after command
11 0 00 00
11 1 00 00
11 2 00 00
11 3 00 00
11 4 00 00
11 5 00 00
11 6 00 00
11 7 00 00
20 0 a5 00
20 1 3c 00
20 2 7e 00
20 3 ff 00
20 4 c3 00
20 5 12 00
20 6 34 00
20 7 56 00
21 0 00 a5
21 1 00 3c
21 2 00 7e
21 3 00 00
21 4 00 c3
21 5 00 12
21 6 00 34
21 7 00 56
40 8 ff 00
40 a aa 00
40 c 55 00
40 f 01 00
41 9 00 00
41 b 00 00
41 e 00 00
41 f 00 00
41 0 00 a5
41 2 00 7e
41 4 00 c3
41 7 00 56
52 1 5a 00
51 1 00 3c
52 6 ff 00
51 6 00 34
50 6 99 00
51 6 00 99

/* verif/ledspi_properties.sv */
`default_nettype none

module ledspi_properties (
	input logic              clk,
	input logic              rst_n,
	input logic              stb,
	input logic              ack,
	input ledspi_pkg::addr_t adr
);
	timeunit 1ns;
	timeprecision 1ps;

	// read by the testbench at the end of the run
	int fail_count = 0;

	// request held with a stable address until ack
	stb_held: assert property (@(posedge clk) disable iff (!rst_n)
		stb && !ack |=> stb && $stable(adr))
		else begin
			$error("stb dropped or adr changed before ack");
			fail_count++;
		end

	// master releases stb right after the ack cycle
	stb_release: assert property (@(posedge clk) disable iff (!rst_n)
		stb && ack |=> !stb)
		else begin
			$error("stb still high in the cycle after ack");
			fail_count++;
		end

	// single cycle ack
	ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		ack |=> !ack)
		else begin
			$error("ack high two cycles in a row");
			fail_count++;
		end

	// no bus request while held in reset
	reset_quiet: assert property (@(posedge clk) !rst_n |=> !stb)
		else begin
			$error("stb high during reset");
			fail_count++;
		end

endmodule

bind spi_wb_ctrl ledspi_properties u_props (
	.clk   (clk),
	.rst_n (rst_n),
	.stb   (stb),
	.ack   (ack),
	.adr   (adr)
);

`default_nettype wire

/* verif/ledspi_tb.sv */
`default_nettype none

module ledspi_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import ledspi_pkg::*;

	localparam int half_clk = 10;
	localparam int gap_clk = 4;
	localparam int reset_clk = 16;
	localparam int max_lines = 64;
	localparam int rand_ops = 12;
	// pwm writes plus scratch traffic, on top of the table
	localparam int extra_frames = 24;

	logic clk;
	logic rst_n;
	logic spi_sck;
	logic spi_csn;
	logic spi_sdi;
	logic spi_sdo;
	logic [2:0] rgb;
	data_t debug;

	// four bytes per table line
	logic [7:0] pat [0:4*max_lines-1];
	data_t scratch [3];
	int n_lines;
	int cycle_limit;
	int cycles = 0;
	int errors;
	int test_errors;
	int checks;
	int tests_run;
	int tests_failed;
	int assert_fails;

	tb_clkgen #(
		.period_ns(20)
	) u_clk (
		.clk(clk)
	);

	ledspi_top #(
		.addr_len(4)
	) u_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.spi_sck (spi_sck),
		.spi_csn (spi_csn),
		.spi_sdi (spi_sdi),
		.spi_sdo (spi_sdo),
		.rgb     (rgb),
		.debug   (debug)
	);

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			$display("FAILED %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, expected);
			errors++;
			test_errors++;
		end
	endtask

	function automatic string test_name(input int id);
		case (id)
		1: return "reset state";
		2: return "register read-back";
		3: return "pwm duty";
		4: return "unmapped addresses";
		5: return "aborted frames";
		6: return "random scratch";
		default: return "unknown";
		endcase
	endfunction

	task automatic finish_test(input int id);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0d %s: passed", id, test_name(id));
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d mismatches", id, test_name(id), test_errors);
		end
		test_errors = 0;
	endtask

	// one mode 0 bit, entered and left right after a rising clk
	task automatic spi_bit(input logic out_bit, output logic in_bit);
		spi_sdi <= out_bit;
		repeat (half_clk - 1) @(posedge clk);
		// sdo settled long before the rising sck
		@(negedge clk);
		in_bit = spi_sdo;
		@(posedge clk);
		spi_sck <= 1'b1;
		repeat (half_clk) @(posedge clk);
		spi_sck <= 1'b0;
	endtask

	// command byte, then data_bits of the second byte, then csn high
	task automatic spi_frame(input data_t cmd, input data_t data, input int data_bits,
		output data_t rd);
		logic b;
		data_t rx;
		rx = '0;
		spi_csn <= 1'b0;
		repeat (half_clk) @(posedge clk);
		for (int i = 7; i >= 0; i--)
			spi_bit(cmd[i], b);
		for (int i = 7; i > 7 - data_bits; i--) begin
			spi_bit(data[i], b);
			rx = {rx[6:0], b};
		end
		repeat (half_clk) @(posedge clk);
		spi_csn <= 1'b1;
		repeat (gap_clk) @(posedge clk);
		rd = rx;
	endtask

	task automatic write_reg(input addr_t addr, input data_t data);
		data_t unused;
		spi_frame({1'b1, 3'b000, addr}, data, 8, unused);
	endtask

	task automatic read_reg(input addr_t addr, output data_t rd);
		spi_frame({1'b0, 3'b000, addr}, 8'h00, 8, rd);
	endtask

	// cut after the command byte plus 0..7 data bits
	task automatic abort_write(input addr_t addr, input data_t data);
		data_t unused;
		int bits;
		bits = int'($urandom % 8);
		spi_frame({1'b1, 3'b000, addr}, data, bits, unused);
	endtask

	task automatic replay_patterns();
		logic [7:0] kind;
		logic [3:0] cur;
		addr_t addr;
		data_t data;
		data_t expected;
		data_t rd;
		cur = pat[0][7:4];
		for (int n = 0; n < n_lines; n++) begin
			kind = pat[4*n];
			addr = pat[4*n+1][3:0];
			data = pat[4*n+2];
			expected = pat[4*n+3];
			// test number change closes the previous test
			if (kind[7:4] != cur) begin
				finish_test(cur);
				cur = kind[7:4];
			end
			case (kind[3:0])
			4'h0: begin
				write_reg(addr, data);
				if (addr == DBG_BASE) begin
					@(negedge clk);
					check_value("debug", debug, data);
					@(posedge clk);
				end
			end
			4'h1: begin
				read_reg(addr, rd);
				check_value($sformatf("spi_sdo(adr %h)", addr), rd, expected);
			end
			4'h2: begin
				abort_write(addr, data);
			end
			default: begin
				$display("pattern line %0d has an unknown kind %h", n, kind);
				errors++;
				test_errors++;
			end
			endcase
		end
		finish_test(cur);
	endtask

	task automatic measure_pwm(input duty_t red, input duty_t green, input duty_t blue);
		duty_t duty [3];
		int high [3];
		duty[0] = red;
		duty[1] = green;
		duty[2] = blue;
		for (int i = 0; i < 3; i++) begin
			write_reg(RGB_BASE + addr_t'(i), duty[i]);
			high[i] = 0;
		end
		// one full counter period
		repeat (256) begin
			@(negedge clk);
			for (int i = 0; i < 3; i++)
				if (rgb[i])
					high[i]++;
		end
		@(posedge clk);
		for (int i = 0; i < 3; i++)
			check_value($sformatf("rgb[%0d] high cycles", i), high[i], duty[i]);
	endtask

	task automatic scratch_test();
		int idx;
		data_t d;
		data_t rd;
		// seed the model with known contents first
		for (int i = 0; i < 3; i++) begin
			d = data_t'($urandom);
			write_reg(DBG_BASE + addr_t'(i + 1), d);
			scratch[i] = d;
		end
		repeat (rand_ops) begin
			idx = int'($urandom % 3);
			if ($urandom % 2) begin
				d = data_t'($urandom);
				write_reg(DBG_BASE + addr_t'(idx + 1), d);
				scratch[idx] = d;
			end else begin
				read_reg(DBG_BASE + addr_t'(idx + 1), rd);
				check_value($sformatf("spi_sdo(adr %h)", DBG_BASE + addr_t'(idx + 1)), rd,
					scratch[idx]);
			end
		end
		for (int i = 0; i < 3; i++) begin
			read_reg(DBG_BASE + addr_t'(i + 1), rd);
			check_value($sformatf("spi_sdo(adr %h)", DBG_BASE + addr_t'(i + 1)), rd, scratch[i]);
		end
		finish_test(6);
	endtask

	// run limit from the frame count
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d clk cycles", cycle_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		spi_sck = 1'b0;
		spi_csn = 1'b1;
		spi_sdi = 1'b0;
		errors = 0;
		test_errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'hfdec_f420));
		$readmemh("verif/ledspi_patterns.hex", pat);
		// table ends at the first unfilled line
		n_lines = 0;
		while (n_lines < max_lines && !$isunknown(pat[4*n_lines]))
			n_lines++;
		cycle_limit = reset_clk + (n_lines + extra_frames) * 400 + 4096;
		repeat (reset_clk) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);
		// pins quiet before any frame
		@(negedge clk);
		check_value("rgb", rgb, 0);
		check_value("debug", debug, 0);
		@(posedge clk);
		if (n_lines == 0) begin
			$display("pattern file is empty or could not be read");
			errors++;
		end else begin
			replay_patterns();
		end
		measure_pwm(8'h00, 8'h01, 8'h80);
		measure_pwm(8'hff, 8'h80, 8'h01);
		finish_test(3);
		scratch_test();
		assert_fails = u_dut.u_bridge.u_props.fail_count;
		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests_run, tests_failed, checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
`default_nettype none

module tb_clkgen #(
	parameter int period_ns = 20
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	// starts low, first rising edge half a period in
	initial clk = 1'b0;

	always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire
